// ==== Makefile ====
# Verilator lint and simulation of the CoCo host I/O block

VERILATOR  ?= verilator
TOP        ?= tb_coco_io
RTL_TOP    ?= coco_io_top
FILELIST   ?= coco_io.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TESTS PASSED
RTL_SRCS   ?= hw/coco_io_pkg.sv hw/tape_adc_slicer.sv hw/machine_reset_ctrl.sv \
              hw/joystick_router.sv hw/cassette_audio_mix.sv hw/coco_io_top.sv
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== coco_io.f ====
hw/coco_io_pkg.sv
hw/tape_adc_slicer.sv
hw/machine_reset_ctrl.sv
hw/joystick_router.sv
hw/cassette_audio_mix.sv
hw/coco_io_top.sv
testbench/coco_io_checker.sv
testbench/tb_coco_io.sv

// ==== hw/cassette_audio_mix.sv ====
////////////////////////////////////////////////////////////
// Cassette audio mix
// Picks the tape bit the machine reads and builds the
// 16-bit sound word, with optional tape monitoring
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cassette_audio_mix
	import coco_io_pkg::*;
(
	input  logic               i_tape_from_adc,
	input  logic               i_tape_monitor,
	input  logic               i_adc_tape_bit,
	input  logic               i_file_tape_bit,
	input  logic               i_snd_bit,
	input  logic [ADC_W-1:0]   i_sound,
	output logic               o_cas_in,
	output logic [AUDIO_W-1:0] o_audio
);

	// Tape bit as heard on the monitor
	logic mon_bit;

	// ADC input or the file player
	assign o_cas_in = i_tape_from_adc ? i_adc_tape_bit : i_file_tape_bit;

	assign mon_bit = i_tape_monitor & o_cas_in;

	// Mix levels, loudest first:
	// one bit sound on the MSB
	// machine sound below it
	// tape monitor at a low level on sound bit 5
	// three zero bits pad to 16
	assign o_audio = {
		i_snd_bit,
		i_sound[11:6],
		i_sound[5] ^ mon_bit,
		i_sound[4:0],
		3'b000
	};

endmodule

`default_nettype wire

// ==== hw/coco_io_pkg.sv ====
////////////////////////////////////////////////////////////
// CoCo host I/O package
// Shared widths, machine and sequencer encodings and the
// default settings of the host-side I/O glue
////////////////////////////////////////////////////////////

`default_nettype none

package coco_io_pkg;

	// Bus widths
	parameter int ADC_W   = 12;
	parameter int AUDIO_W = 16;
	parameter int JOY_W   = 32;
	// Analog pair, Y byte high and X byte low
	parameter int AJOY_W  = 16;

	// Machine choice from the host menu
	// Code 3 is not listed and decodes like a Dragon 32
	typedef enum logic [1:0] {
		MACH_COCO2    = 2'd0,
		MACH_DRAGON32 = 2'd1,
		MACH_DRAGON64 = 2'd2
	} machine_e;

	// Hard reset pulse sequencer
	typedef enum logic {
		HARD_IDLE  = 1'b0,
		HARD_PULSE = 1'b1
	} hard_state_e;

	// Defaults, 512 samples of history
	parameter int DEF_AVG_LOG2   = 9;
	// Roughly 0.1 V away from the average
	parameter int DEF_THRESHOLD  = 100;
	parameter int DEF_RESET_HOLD = 15;

	// Offset that moves a signed axis byte to unsigned
	parameter int AXIS_CENTRE = 128;

endpackage

`default_nettype wire

// ==== hw/coco_io_top.sv ====
////////////////////////////////////////////////////////////
// CoCo host I/O top level
// Cassette slicer, machine reset sequencer, joystick
// router and cassette audio mix of the emulator wrapper
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module coco_io_top
	import coco_io_pkg::*;
#(
	parameter int AVG_LOG2   = DEF_AVG_LOG2,
	parameter int THRESHOLD  = DEF_THRESHOLD,
	parameter int RESET_HOLD = DEF_RESET_HOLD
)
(
	input  logic               clk_sys,
	input  logic               i_rst_n,

	// ADC samples, one per sync toggle
	input  logic [ADC_W-1:0]   i_adc_data,
	input  logic               i_adc_sync,

	// Tape and sound
	input  logic               i_tape_from_adc,
	input  logic               i_tape_monitor,
	input  logic               i_file_tape_bit,
	input  logic               i_snd_bit,
	input  logic [ADC_W-1:0]   i_sound,

	// Joysticks
	input  logic               i_swap_joy,
	input  logic [JOY_W-1:0]   i_joy1,
	input  logic [JOY_W-1:0]   i_joy2,
	input  logic [AJOY_W-1:0]  i_ajoy1,
	input  logic [AJOY_W-1:0]  i_ajoy2,

	// Machine choice and hard reset request
	input  logic [1:0]         i_machine_sel,
	input  logic               i_hard_reset_req,

	output logic [ADC_W-1:0]   o_adc_value,
	output logic               o_cas_in,
	output logic [AUDIO_W-1:0] o_audio,
	output logic [JOY_W-1:0]   o_joy1,
	output logic [JOY_W-1:0]   o_joy2,
	output logic [AJOY_W-1:0]  o_ajoy1,
	output logic [AJOY_W-1:0]  o_ajoy2,
	output logic               o_dragon,
	output logic               o_dragon64,
	output logic               o_hard_reset,
	output logic               o_machine_reset
);

	// Sliced ADC tape bit into the source select
	logic adc_tape_bit;

	tape_adc_slicer #(
		.AVG_LOG2  (AVG_LOG2),
		.THRESHOLD (THRESHOLD)
	) u_slicer (
		.clk_sys     (clk_sys),
		.i_rst_n     (i_rst_n),
		.i_adc_data  (i_adc_data),
		.i_adc_sync  (i_adc_sync),
		.o_adc_value (o_adc_value),
		.o_tape_bit  (adc_tape_bit)
	);

	cassette_audio_mix u_audio_mix (
		.i_tape_from_adc (i_tape_from_adc),
		.i_tape_monitor  (i_tape_monitor),
		.i_adc_tape_bit  (adc_tape_bit),
		.i_file_tape_bit (i_file_tape_bit),
		.i_snd_bit       (i_snd_bit),
		.i_sound         (i_sound),
		.o_cas_in        (o_cas_in),
		.o_audio         (o_audio)
	);

	// Menu code 3 passes through and decodes like a Dragon 32
	machine_reset_ctrl #(
		.RESET_HOLD (RESET_HOLD)
	) u_reset_ctrl (
		.clk_sys          (clk_sys),
		.i_rst_n          (i_rst_n),
		.i_machine_sel    (machine_e'(i_machine_sel)),
		.i_hard_reset_req (i_hard_reset_req),
		.o_dragon         (o_dragon),
		.o_dragon64       (o_dragon64),
		.o_hard_reset     (o_hard_reset),
		.o_machine_reset  (o_machine_reset)
	);

	joystick_router u_joy_router (
		.i_swap_joy (i_swap_joy),
		.i_joy1     (i_joy1),
		.i_joy2     (i_joy2),
		.i_ajoy1    (i_ajoy1),
		.i_ajoy2    (i_ajoy2),
		.o_joy1     (o_joy1),
		.o_joy2     (o_joy2),
		.o_ajoy1    (o_ajoy1),
		.o_ajoy2    (o_ajoy2)
	);

endmodule

`default_nettype wire

// ==== hw/joystick_router.sv ====
////////////////////////////////////////////////////////////
// Joystick router
// Re-centres the signed analog axes and swaps the two
// players on request
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module joystick_router
	import coco_io_pkg::*;
(
	input  logic              i_swap_joy,
	input  logic [JOY_W-1:0]  i_joy1,
	input  logic [JOY_W-1:0]  i_joy2,
	input  logic [AJOY_W-1:0] i_ajoy1,
	input  logic [AJOY_W-1:0] i_ajoy2,
	output logic [JOY_W-1:0]  o_joy1,
	output logic [JOY_W-1:0]  o_joy2,
	output logic [AJOY_W-1:0] o_ajoy1,
	output logic [AJOY_W-1:0] o_ajoy2
);

	// Centred analog words, byte order unchanged
	logic [AJOY_W-1:0] ajoy1_c;
	logic [AJOY_W-1:0] ajoy2_c;

	// Signed -128..127 becomes 0..255 with rest at 128
	function automatic logic [AJOY_W-1:0] centre_axes(input logic [AJOY_W-1:0] raw);
		logic [7:0] y_axis;
		logic [7:0] x_axis;
		y_axis = raw[15:8] + 8'(AXIS_CENTRE);
		x_axis = raw[7:0] + 8'(AXIS_CENTRE);
		return {y_axis, x_axis};
	endfunction

	assign ajoy1_c = centre_axes(i_ajoy1);
	assign ajoy2_c = centre_axes(i_ajoy2);

	////////////////////////////////////////////////////////////
	// Player swap
	////////////////////////////////////////////////////////////

	// Digital and analog move together
	assign o_joy1  = i_swap_joy ? i_joy2  : i_joy1;
	assign o_joy2  = i_swap_joy ? i_joy1  : i_joy2;
	assign o_ajoy1 = i_swap_joy ? ajoy2_c : ajoy1_c;
	assign o_ajoy2 = i_swap_joy ? ajoy1_c : ajoy2_c;

endmodule

`default_nettype wire

// ==== hw/machine_reset_ctrl.sv ====
////////////////////////////////////////////////////////////
// Machine select and reset sequencer
// Decodes the machine choice and stretches the machine
// reset on a choice change or a hard reset request, which
// also gives a one cycle hard reset pulse
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module machine_reset_ctrl
	import coco_io_pkg::*;
#(
	parameter int RESET_HOLD = DEF_RESET_HOLD
)
(
	input  logic     clk_sys,
	input  logic     i_rst_n,
	input  machine_e i_machine_sel,
	input  logic     i_hard_reset_req,
	output logic     o_dragon,
	output logic     o_dragon64,
	output logic     o_hard_reset,
	output logic     o_machine_reset
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	// Delayed copies for change detection
	machine_e    sel_d;
	logic        hard_req_d;
	logic        sel_change;
	logic        hard_change;

	// Decoded machine flags
	logic        dragon_dec;
	logic        dragon64_dec;

	logic [CNT_W-1:0] hold_cnt;
	hard_state_e      hard_state;

	assign sel_change  = (i_machine_sel != sel_d);
	assign hard_change = (i_hard_reset_req != hard_req_d);

	// Anything that is not a CoCo 2 runs the Dragon ROMs
	always_comb
	begin
		case (i_machine_sel)
			MACH_COCO2:    {dragon_dec, dragon64_dec} = 2'b00;
			MACH_DRAGON32: {dragon_dec, dragon64_dec} = 2'b10;
			MACH_DRAGON64: {dragon_dec, dragon64_dec} = 2'b11;
			default:       {dragon_dec, dragon64_dec} = 2'b10;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Reset stretch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (!i_rst_n)
		begin
			// Load copies from the inputs so release sees no change
			sel_d           <= i_machine_sel;
			hard_req_d      <= i_hard_reset_req;
			hold_cnt        <= '0;
			o_machine_reset <= 1'b0;
			o_dragon        <= 1'b0;
			o_dragon64      <= 1'b0;
		end
		else
		begin
			sel_d      <= i_machine_sel;
			hard_req_d <= i_hard_reset_req;
			o_dragon   <= dragon_dec;
			o_dragon64 <= dragon64_dec;

			o_machine_reset <= (hold_cnt != '0);
			// A new change restarts the hold
			if (sel_change || hard_change)
				hold_cnt <= CNT_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Hard reset pulse FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (!i_rst_n)
		begin
			hard_state   <= HARD_IDLE;
			o_hard_reset <= 1'b0;
		end
		else
		begin
			o_hard_reset <= (hard_state == HARD_PULSE);
			case (hard_state)
				HARD_IDLE:
					if (hard_change)
						hard_state <= HARD_PULSE;
				// A request during the pulse still stretches the reset
				default:
					hard_state <= HARD_IDLE;
			endcase
		end
	end

	// Pulse is a single cycle, two cycles after a request change
	a_hard_single: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		o_hard_reset |-> $past(hard_change, 2) && !$past(o_hard_reset));

	// Hard reset always sits inside the stretched reset
	a_hard_in_reset: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		o_hard_reset |-> o_machine_reset);

endmodule

`default_nettype wire

// ==== hw/tape_adc_slicer.sv ====
////////////////////////////////////////////////////////////
// Cassette ADC slicer
// Keeps a running average of the last 2**AVG_LOG2 ADC
// samples and slices each new sample into a tape bit with
// hysteresis of THRESHOLD counts around that average
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tape_adc_slicer
	import coco_io_pkg::*;
#(
	parameter int AVG_LOG2  = DEF_AVG_LOG2,
	parameter int THRESHOLD = DEF_THRESHOLD
)
(
	input  logic             clk_sys,
	input  logic             i_rst_n,
	input  logic [ADC_W-1:0] i_adc_data,
	input  logic             i_adc_sync,
	output logic [ADC_W-1:0] o_adc_value,
	output logic             o_tape_bit
);

	localparam int DEPTH = 1 << AVG_LOG2;
	localparam int SUM_W = ADC_W + AVG_LOG2;

	// Toggle detect and sample capture
	logic             adc_sync_d;
	logic             sync_toggle;
	logic             sample_stb;
	logic [ADC_W-1:0] sample_q;

	// History ring and running sum
	logic [ADC_W-1:0]    hist [DEPTH];
	logic [AVG_LOG2-1:0] wr_ptr;
	logic [SUM_W-1:0]    run_sum;
	logic [ADC_W-1:0]    oldest;
	logic [ADC_W-1:0]    avg;

	// Comparison terms, wide enough that nothing wraps
	logic [31:0] samp_plus_thr;
	logic [31:0] avg_plus_thr;

	// Each level change of the sync line is one new sample
	assign sync_toggle = adc_sync_d ^ i_adc_sync;

	always_ff @(posedge clk_sys)
	begin
		// Copy follows the input even in reset, so release gives no toggle
		adc_sync_d <= i_adc_sync;
		if (!i_rst_n)
			sample_stb <= 1'b0;
		else
			sample_stb <= sync_toggle;
	end

	// Sample is held for the update cycle
	always_ff @(posedge clk_sys)
	begin
		if (sync_toggle)
			sample_q <= i_adc_data;
	end

	////////////////////////////////////////////////////////////
	// Average and hysteresis
	////////////////////////////////////////////////////////////

	// Entry about to be overwritten leaves the sum
	assign oldest = hist[wr_ptr];
	// Average over the window before this sample joins
	assign avg    = run_sum[SUM_W-1:AVG_LOG2];

	assign samp_plus_thr = 32'(sample_q) + 32'(THRESHOLD);
	assign avg_plus_thr  = 32'(avg) + 32'(THRESHOLD);

	always_ff @(posedge clk_sys)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				hist[i] <= '0;
			wr_ptr      <= '0;
			run_sum     <= '0;
			o_adc_value <= '0;
			o_tape_bit  <= 1'b0;
		end
		else if (sample_stb)
		begin
			o_adc_value  <= sample_q;
			hist[wr_ptr] <= sample_q;
			wr_ptr       <= wr_ptr + 1'b1;
			run_sum      <= run_sum - SUM_W'(oldest) + SUM_W'(sample_q);

			// Well below the average sets the bit, polarity as on the real machine
			if (samp_plus_thr < 32'(avg))
				o_tape_bit <= 1'b1;
			// Well above clears it; inside the band it holds
			else if (32'(sample_q) > avg_plus_thr)
				o_tape_bit <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Ring only moves two cycles after a sync toggle
	a_ptr_on_sample: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		$changed(wr_ptr) |-> $past(sync_toggle, 2));

	// Tape bit only flips two cycles after a sync toggle
	a_bit_on_sample: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		$changed(o_tape_bit) |-> $past(sync_toggle, 2));

endmodule

`default_nettype wire

// ==== testbench/coco_io_checker.sv ====
////////////////////////////////////////////////////////////
// CoCo host I/O checker
// Models the slicer, tape mix, joystick router and reset
// sequencer and counts mismatches per group
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module coco_io_checker
	import coco_io_pkg::*;
#(
	parameter int AVG_LOG2   = DEF_AVG_LOG2,
	parameter int THRESHOLD  = DEF_THRESHOLD,
	parameter int RESET_HOLD = DEF_RESET_HOLD
)
(
	input  logic               clk_sys,
	input  logic               i_rst_n,
	input  logic [ADC_W-1:0]   i_adc_data,
	input  logic               i_adc_sync,
	input  logic               i_tape_from_adc, i_tape_monitor, i_file_tape_bit, i_snd_bit,
	input  logic [ADC_W-1:0]   i_sound,
	input  logic               i_swap_joy,
	input  logic [JOY_W-1:0]   i_joy1, i_joy2,
	input  logic [AJOY_W-1:0]  i_ajoy1, i_ajoy2,
	input  logic [1:0]         i_machine_sel,
	input  logic               i_hard_reset_req,
	input  logic [ADC_W-1:0]   o_adc_value,
	input  logic               o_cas_in,
	input  logic [AUDIO_W-1:0] o_audio,
	input  logic [JOY_W-1:0]   o_joy1, o_joy2,
	input  logic [AJOY_W-1:0]  o_ajoy1, o_ajoy2,
	input  logic               o_dragon, o_dragon64, o_hard_reset, o_machine_reset,
	output int                 o_err_tape, o_err_audio, o_err_joy, o_err_ctrl
);

	localparam int DEPTH = 1 << AVG_LOG2;

	// Error groups: 0 tape, 1 audio, 2 joystick, 3 control
	int err_cnt [4] = '{0, 0, 0, 0};
	logic checks_on = 1'b0;

	// Slicer model, window holds the last DEPTH samples oldest first
	int               window[$];
	int               samp;
	logic             pend;
	logic             sync_prev;
	logic [ADC_W-1:0] exp_val;
	logic             exp_bit;

	// Sequencer model, cycle numbers of the latest changes
	int         cyc = 0;
	int         last_chg;
	int         last_hard;
	logic [1:0] sel_prev;
	logic       req_prev;
	logic       exp_dragon;
	logic       exp_dragon64;

	assign o_err_tape  = err_cnt[0];
	assign o_err_audio = err_cnt[1];
	assign o_err_joy   = err_cnt[2];
	assign o_err_ctrl  = err_cnt[3];

	task automatic compare_output(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v, input int grp);
		if (act_v !== exp_v)
		begin
			$display("Error: %s expected %0h got %0h at %0t", name, exp_v, act_v, $time);
			err_cnt[grp]++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Slicer model
	////////////////////////////////////////////////////////////

	always @(posedge clk_sys)
	begin : slicer_model
		int total;
		int avg;
		if (!i_rst_n)
		begin
			window.delete();
			repeat (DEPTH) window.push_back(0);
			pend      = 1'b0;
			exp_val   = '0;
			exp_bit   = 1'b0;
			checks_on = 1'b1;
		end
		else
		begin
			// Sample seen on the previous edge takes effect now
			if (pend)
			begin
				total = 0;
				foreach (window[i])
					total += window[i];
				avg = total / DEPTH;
				if (samp + THRESHOLD < avg)
					exp_bit = 1'b1;
				else if (samp > avg + THRESHOLD)
					exp_bit = 1'b0;
				void'(window.pop_front());
				window.push_back(samp);
				exp_val = ADC_W'(samp);
			end
			pend = (i_adc_sync != sync_prev);
			if (pend)
				samp = int'(i_adc_data);
		end
		sync_prev = i_adc_sync;
	end

	////////////////////////////////////////////////////////////
	// Sequencer model
	////////////////////////////////////////////////////////////

	always @(posedge clk_sys)
	begin
		cyc = cyc + 1;
		if (!i_rst_n)
		begin
			// Far in the past, so no window is open after reset
			last_chg     = -1000;
			last_hard    = -1000;
			exp_dragon   = 1'b0;
			exp_dragon64 = 1'b0;
		end
		else
		begin
			if ((i_machine_sel != sel_prev) || (i_hard_reset_req != req_prev))
				last_chg = cyc;
			if (i_hard_reset_req != req_prev)
				last_hard = cyc;
			// Every code but zero is a Dragon
			exp_dragon   = (i_machine_sel != 2'd0);
			exp_dragon64 = (i_machine_sel == 2'd2);
		end
		sel_prev = i_machine_sel;
		req_prev = i_hard_reset_req;
	end

	// Outputs are settled at the falling edge
	always @(negedge clk_sys)
	begin : compare_all
		logic                exp_cas;
		logic [AUDIO_W-1:0]  exp_audio;
		logic                exp_mreset;
		logic                exp_hard;
		if (checks_on)
		begin
			exp_cas = i_tape_from_adc ? exp_bit : i_file_tape_bit;
			// Sound bit 5 sits at audio bit 8
			exp_audio = {i_snd_bit, i_sound, 3'b000} ^ (16'(i_tape_monitor & exp_cas) << 8);
			exp_mreset = ((cyc - last_chg) >= 1) && ((cyc - last_chg) <= RESET_HOLD);
			exp_hard = ((cyc - last_hard) == 1);
			compare_output("o_adc_value", 32'(exp_val), 32'(o_adc_value), 0);
			compare_output("o_cas_in", 32'(exp_cas), 32'(o_cas_in), 0);
			compare_output("o_audio", 32'(exp_audio), 32'(o_audio), 1);
			compare_output("o_joy1", i_swap_joy ? i_joy2 : i_joy1, o_joy1, 2);
			compare_output("o_joy2", i_swap_joy ? i_joy1 : i_joy2, o_joy2, 2);
			// Adding 128 modulo 256 flips the top bit of each axis byte
			compare_output("o_ajoy1", 32'((i_swap_joy ? i_ajoy2 : i_ajoy1) ^ 16'h8080),
				32'(o_ajoy1), 2);
			compare_output("o_ajoy2", 32'((i_swap_joy ? i_ajoy1 : i_ajoy2) ^ 16'h8080),
				32'(o_ajoy2), 2);
			compare_output("o_dragon", 32'(exp_dragon), 32'(o_dragon), 3);
			compare_output("o_dragon64", 32'(exp_dragon64), 32'(o_dragon64), 3);
			compare_output("o_machine_reset", 32'(exp_mreset), 32'(o_machine_reset), 3);
			compare_output("o_hard_reset", 32'(exp_hard), 32'(o_hard_reset), 3);
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_coco_io.sv ====
////////////////////////////////////////////////////////////
// CoCo host I/O testbench
// Applies a table of tape, audio, joystick and machine
// steps to the top level and reports the checker's counts
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_coco_io
	import coco_io_pkg::*;
();

	localparam int CLK_HALF    = 20;
	localparam int TB_AVG_LOG2 = 4;
	// Cycles allowed per step, a machine step needs about 18
	localparam int STEP_BUDGET = 20;

	typedef enum logic [2:0] {
		STEP_SAMPLE,
		STEP_RAND_SAMPLE,
		STEP_SOURCE,
		STEP_AUDIO,
		STEP_JOY,
		STEP_MACHINE,
		STEP_HARD
	} step_kind_e;

	typedef struct packed {
		step_kind_e  kind;
		logic [31:0] value;
	} step_t;

	logic               clk_sys, i_rst_n;
	logic [ADC_W-1:0]   i_adc_data, i_sound, o_adc_value;
	logic               i_adc_sync, i_tape_from_adc, i_tape_monitor, i_file_tape_bit;
	logic               i_snd_bit, i_swap_joy, i_hard_reset_req;
	logic [JOY_W-1:0]   i_joy1, i_joy2, o_joy1, o_joy2;
	logic [AJOY_W-1:0]  i_ajoy1, i_ajoy2, o_ajoy1, o_ajoy2;
	logic [1:0]         i_machine_sel;
	logic               o_cas_in, o_dragon, o_dragon64, o_hard_reset, o_machine_reset;
	logic [AUDIO_W-1:0] o_audio;
	int                 err_tape, err_audio, err_joy, err_ctrl;

	step_t steps[$];
	int    n_steps = 0;

	coco_io_top #(
		.AVG_LOG2   (TB_AVG_LOG2),
		.THRESHOLD  (DEF_THRESHOLD),
		.RESET_HOLD (DEF_RESET_HOLD)
	) UUT (.*);

	coco_io_checker #(
		.AVG_LOG2   (TB_AVG_LOG2),
		.THRESHOLD  (DEF_THRESHOLD),
		.RESET_HOLD (DEF_RESET_HOLD)
	) u_checker (
		.o_err_tape  (err_tape),
		.o_err_audio (err_audio),
		.o_err_joy   (err_joy),
		.o_err_ctrl  (err_ctrl),
		.*
	);

	always #CLK_HALF clk_sys = ~clk_sys;

	task automatic add_step(input step_kind_e kind, input int value);
		steps.push_back('{kind: kind, value: value});
	endtask

	task automatic build_table();
		// Steady level fills the window
		repeat (20) add_step(STEP_SAMPLE, 2048);
		// Well below the average sets the bit
		repeat (4) add_step(STEP_SAMPLE, 1700);
		// Inside the band it holds
		repeat (3) add_step(STEP_SAMPLE, 1990);
		repeat (4) add_step(STEP_SAMPLE, 2400);
		repeat (3) add_step(STEP_SAMPLE, 2000);
		repeat (16) add_step(STEP_RAND_SAMPLE, 0);
		// Source value, bit 1 file level and bit 0 ADC select
		add_step(STEP_SOURCE, 2);
		add_step(STEP_SOURCE, 0);
		add_step(STEP_SOURCE, 2);
		repeat (6) add_step(STEP_AUDIO, 1);
		repeat (6) add_step(STEP_AUDIO, 0);
		add_step(STEP_SOURCE, 1);
		repeat (4) add_step(STEP_AUDIO, 1);
		repeat (6) add_step(STEP_JOY, 0);
		repeat (6) add_step(STEP_JOY, 1);
		// Every machine code, code 3 included
		add_step(STEP_MACHINE, 1);
		add_step(STEP_MACHINE, 2);
		add_step(STEP_MACHINE, 3);
		add_step(STEP_MACHINE, 0);
		add_step(STEP_MACHINE, 2);
		repeat (2) add_step(STEP_HARD, 0);
	endtask

	task automatic run_step(input step_t s);
		@(posedge clk_sys);
		#2;
		case (s.kind)
			STEP_SAMPLE, STEP_RAND_SAMPLE:
			begin
				i_adc_data = (s.kind == STEP_SAMPLE) ? ADC_W'(s.value) : ADC_W'($urandom);
				i_adc_sync = ~i_adc_sync;
			end
			STEP_SOURCE:
			begin
				i_tape_from_adc = s.value[0];
				i_file_tape_bit = s.value[1];
			end
			STEP_AUDIO:
			begin
				i_tape_monitor = s.value[0];
				i_sound        = ADC_W'($urandom);
				i_snd_bit      = 1'($urandom);
			end
			STEP_JOY:
			begin
				i_swap_joy = s.value[0];
				i_joy1     = $urandom;
				i_joy2     = $urandom;
				i_ajoy1    = AJOY_W'($urandom);
				i_ajoy2    = AJOY_W'($urandom);
			end
			STEP_MACHINE:
				i_machine_sel = s.value[1:0];
			default:
				i_hard_reset_req = ~i_hard_reset_req;
		endcase
		if (s.kind == STEP_MACHINE || s.kind == STEP_HARD)
		begin
			// Let the stretched reset rise and fall again
			@(negedge clk_sys);
			while (!o_machine_reset)
				@(negedge clk_sys);
			while (o_machine_reset)
				@(negedge clk_sys);
		end
		else
			repeat (2) @(posedge clk_sys);
	endtask

	initial
	begin
		void'($urandom(99));
		clk_sys          = 1'b0;
		i_rst_n          = 1'b0;
		i_adc_data       = '0;
		i_adc_sync       = 1'b0;
		i_tape_from_adc  = 1'b1;
		i_tape_monitor   = 1'b0;
		i_file_tape_bit  = 1'b0;
		i_snd_bit        = 1'b0;
		i_sound          = '0;
		i_swap_joy       = 1'b0;
		i_joy1           = '0;
		i_joy2           = '0;
		i_ajoy1          = '0;
		i_ajoy2          = '0;
		i_machine_sel    = 2'd0;
		i_hard_reset_req = 1'b0;
		build_table();
		n_steps = steps.size();
		repeat (2) @(posedge clk_sys);
		#2;
		i_rst_n = 1'b1;
		foreach (steps[i])
			run_step(steps[i]);
		repeat (3) @(negedge clk_sys);
		$display("Summary: tape errors %0d, audio errors %0d, joystick errors %0d, control errors %0d",
			err_tape, err_audio, err_joy, err_ctrl);
		if (err_tape + err_audio + err_joy + err_ctrl == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (n_steps > 0);
		repeat (n_steps * STEP_BUDGET + 200) @(posedge clk_sys);
		$display("Timeout: the step table did not finish within %0d cycles",
			n_steps * STEP_BUDGET + 200);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
